/* source/psum_pkg.sv */
// Partial-sum bank package: widths, word types, pass config and bank states
package psum_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int PSUM_W = 32;
  localparam int LANES  = 4;
  localparam int CH_W   = 2;
  localparam int WORD_W = 4;
  localparam int LANE_W = 2;

  // ==================================================
  // Vector types
  // ==================================================
  // One signed partial sum
  typedef logic signed [PSUM_W-1:0] psum_t;

  // One RAM word, lane 0 in the low bits
  typedef logic [LANES*PSUM_W-1:0] psum_word_t;

  // Channel index over word index
  typedef logic [CH_W+WORD_W-1:0] bank_addr_t;

  typedef logic [CH_W-1:0]   ch_idx_t;
  typedef logic [WORD_W-1:0] word_idx_t;
  typedef logic [LANE_W-1:0] lane_idx_t;

  // Extra bit so a full region count fits
  typedef logic [WORD_W:0] beat_cnt_t;

  // ==================================================
  // Structs and states
  // ==================================================
  typedef struct packed {
    logic first_pass;
    logic last_pass;
  } pass_cfg_t;

  typedef struct packed {
    ch_idx_t   ch;
    word_idx_t word;
    lane_idx_t lane;
  } pool_addr_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    FLUSH,
    POOL
  } bank_state_e;

  // RAM address of a word inside a channel region
  function automatic bank_addr_t bank_addr(ch_idx_t ch, word_idx_t word);
    return {ch, word};
  endfunction

endpackage

/* source/psum_rr_arb.sv */
// Round-robin arbiter keeping a rotating priority order over channel requests
`timescale 1ns/1ps

module psum_rr_arb #(
  parameter int NUM_CH = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [NUM_CH-1:0] req_i,
  input  logic              adv_i,
  output psum_pkg::ch_idx_t grant_o
);
  import psum_pkg::*;

  // Priority order, entry 0 ranks highest
  ch_idx_t id_map [NUM_CH];

  // Rotate by one on every accepted beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CH; i++) begin
        id_map[i] <= ch_idx_t'(i);
      end
    end else if (adv_i) begin
      for (int i = 0; i < NUM_CH; i++) begin
        id_map[i] <= id_map[(i + 1) % NUM_CH];
      end
    end
  end

  // Scan from lowest rank up so the highest-ranked requester is kept
  always_comb begin
    grant_o = '0;
    for (int i = NUM_CH - 1; i >= 0; i--) begin
      if (req_i[id_map[i]]) begin
        grant_o = id_map[i];
      end
    end
  end

endmodule

/* source/psum_ram.sv */
// Dual-port word RAM for the partial-sum regions, registered read port
`timescale 1ns/1ps

module psum_ram #(
  parameter int DEPTH  = 16,
  parameter int NUM_CH = 3
) (
  input  logic                 clk,
  input  logic                 ren_i,
  input  psum_pkg::bank_addr_t raddr_i,
  output psum_pkg::psum_word_t rdata_o,
  input  logic                 wen_i,
  input  psum_pkg::bank_addr_t waddr_i,
  input  psum_pkg::psum_word_t wdata_i
);
  import psum_pkg::*;

  localparam int WORDS = NUM_CH * DEPTH;

  psum_word_t mem [WORDS];

  // Regions are packed back to back, DEPTH words each
  function automatic int row_of(bank_addr_t addr);
    return int'(addr[WORD_W +: CH_W]) * DEPTH + int'(addr[WORD_W-1:0]);
  endfunction

  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem[row_of(waddr_i)] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ren_i) begin
      rdata_o <= mem[row_of(raddr_i)];
    end
  end

endmodule

/* source/psum_accum.sv */
// Write-port grant, per-channel beat counters and read-modify-write accumulate
`timescale 1ns/1ps

module psum_accum #(
  parameter int NUM_CH = 3,
  parameter int DEPTH  = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  psum_pkg::bank_state_e state_i,
  input  psum_pkg::pass_cfg_t   cfg_i,
  input  logic [NUM_CH-1:0]     wr_valid_i,
  input  psum_pkg::psum_word_t  wr_data_i [NUM_CH],
  output logic [NUM_CH-1:0]     wr_ready_o,
  input  psum_pkg::ch_idx_t     grant_i,
  output logic [NUM_CH-1:0]     arb_req_o,
  output logic                  arb_adv_o,
  output logic                  ram_ren_o,
  output psum_pkg::bank_addr_t  ram_raddr_o,
  input  psum_pkg::psum_word_t  ram_rdata_i,
  output logic                  ram_wen_o,
  output psum_pkg::bank_addr_t  ram_waddr_o,
  output psum_pkg::psum_word_t  ram_wdata_o,
  output logic                  accum_done_o
);
  import psum_pkg::*;

  beat_cnt_t         beat_cnt [NUM_CH];
  logic [NUM_CH-1:0] room;
  logic              accept;
  beat_cnt_t         sel_cnt;
  psum_word_t        sel_data;

  // Add/write stage
  logic              stg_vld;
  bank_addr_t        stg_addr;
  psum_word_t        stg_data;
  psum_word_t        base;

  // ==================================================
  // Requests and ready
  // ==================================================
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      room[c]       = beat_cnt[c] < beat_cnt_t'(DEPTH);
      arb_req_o[c]  = (state_i == ACCUM) && wr_valid_i[c] && room[c];
      wr_ready_o[c] = arb_req_o[c] && (grant_i == ch_idx_t'(c));
    end
  end

  // Ready already implies valid
  assign accept    = |wr_ready_o;
  assign arb_adv_o = accept;

  // Count and data of the granted channel
  always_comb begin
    sel_cnt  = '0;
    sel_data = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (grant_i == ch_idx_t'(c)) begin
        sel_cnt  = beat_cnt[c];
        sel_data = wr_data_i[c];
      end
    end
  end

  // Beat counters, cleared between passes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CH; c++) begin
        beat_cnt[c] <= '0;
      end
    end else if (state_i == IDLE) begin
      for (int c = 0; c < NUM_CH; c++) begin
        beat_cnt[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (wr_ready_o[c]) begin
          beat_cnt[c] <= beat_cnt[c] + 1'b1;
        end
      end
    end
  end

  // ==================================================
  // Read stage
  // ==================================================
  assign ram_ren_o   = accept;
  assign ram_raddr_o = bank_addr(grant_i, sel_cnt[WORD_W-1:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_vld <= 1'b0;
    end else begin
      stg_vld <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stg_addr <= ram_raddr_o;
      stg_data <= sel_data;
    end
  end

  // ==================================================
  // Add and write stage
  // ==================================================
  // First pass starts from a zero base
  assign base = cfg_i.first_pass ? '0 : ram_rdata_i;

  // Lane-wise signed add, wraps on overflow
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      ram_wdata_o[l*PSUM_W +: PSUM_W] = psum_t'(stg_data[l*PSUM_W +: PSUM_W])
                                      + psum_t'(base[l*PSUM_W +: PSUM_W]);
    end
  end

  assign ram_wen_o   = stg_vld;
  assign ram_waddr_o = stg_addr;

  // All regions full and nothing left in flight
  assign accum_done_o = ~|room && !stg_vld;

endmodule

/* source/psum_ctrl.sv */
// Pass state machine of the partial-sum bank and its pool read port
`timescale 1ns/1ps

module psum_ctrl #(
  parameter int NUM_CH = 3,
  parameter int DEPTH  = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  psum_pkg::pass_cfg_t   cfg_i,
  input  logic                  accum_done_i,
  input  logic                  pool_req_i,
  input  psum_pkg::pool_addr_t  pool_addr_i,
  input  logic                  pool_fnh_i,
  output psum_pkg::psum_t       pool_data_o,
  output logic                  pool_val_o,
  output logic                  ram_ren_o,
  output psum_pkg::bank_addr_t  ram_raddr_o,
  input  psum_pkg::psum_word_t  ram_rdata_i,
  output psum_pkg::bank_state_e state_o,
  output psum_pkg::pass_cfg_t   cfg_o,
  output logic                  idle_o
);
  import psum_pkg::*;

  bank_state_e state_q;
  bank_state_e state_d;
  pass_cfg_t   cfg_q;
  logic        in_range;
  lane_idx_t   lane_q;

  // ==================================================
  // Pass FSM
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = ACCUM;
        end
      end
      ACCUM: begin
        if (accum_done_i) begin
          state_d = FLUSH;
        end
      end
      // Last pass hands the sums to the pooling unit
      FLUSH: begin
        state_d = cfg_q.last_pass ? POOL : IDLE;
      end
      POOL: begin
        if (pool_fnh_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cfg_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start_i) begin
        cfg_q <= cfg_i;
      end
    end
  end

  assign state_o = state_q;
  assign cfg_o   = cfg_q;
  assign idle_o  = (state_q == IDLE);

  // ==================================================
  // Pool read port
  // ==================================================
  // Requests beyond the populated regions are dropped
  assign in_range = (int'(pool_addr_i.ch) < NUM_CH) && (int'(pool_addr_i.word) < DEPTH);

  assign ram_ren_o   = (state_q == POOL) && pool_req_i && in_range;
  assign ram_raddr_o = bank_addr(pool_addr_i.ch, pool_addr_i.word);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pool_val_o <= 1'b0;
    end else begin
      pool_val_o <= ram_ren_o;
    end
  end

  // Lane follows the word out of the RAM
  always_ff @(posedge clk) begin
    if (ram_ren_o) begin
      lane_q <= pool_addr_i.lane;
    end
  end

  assign pool_data_o = ram_rdata_i[lane_q*PSUM_W +: PSUM_W];

endmodule

/* source/psum_bank_top.sv */
// Partial-sum buffer bank top: arbiter, accumulator, pass control and RAM
`timescale 1ns/1ps

module psum_bank_top #(
  parameter int NUM_CH = 3,
  parameter int DEPTH  = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  psum_pkg::pass_cfg_t  cfg_i,
  output logic                 idle_o,
  input  logic [NUM_CH-1:0]    wr_valid_i,
  input  psum_pkg::psum_word_t wr_data_i [NUM_CH],
  output logic [NUM_CH-1:0]    wr_ready_o,
  input  logic                 pool_req_i,
  input  psum_pkg::pool_addr_t pool_addr_i,
  input  logic                 pool_fnh_i,
  output psum_pkg::psum_t      pool_data_o,
  output logic                 pool_val_o
);
  import psum_pkg::*;

  bank_state_e       state;
  pass_cfg_t         pass_cfg;
  logic [NUM_CH-1:0] arb_req;
  logic              arb_adv;
  ch_idx_t           grant;
  logic              accum_done;

  logic              acc_ren;
  logic              ctrl_ren;
  logic              ram_ren;
  logic              ram_wen;
  bank_addr_t        acc_raddr;
  bank_addr_t        ctrl_raddr;
  bank_addr_t        ram_raddr;
  bank_addr_t        ram_waddr;
  psum_word_t        ram_rdata;
  psum_word_t        ram_wdata;

  psum_rr_arb #(
    .NUM_CH (NUM_CH)
  ) u_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (arb_req),
    .adv_i   (arb_adv),
    .grant_o (grant)
  );

  psum_accum #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state),
    .cfg_i        (pass_cfg),
    .wr_valid_i   (wr_valid_i),
    .wr_data_i    (wr_data_i),
    .wr_ready_o   (wr_ready_o),
    .grant_i      (grant),
    .arb_req_o    (arb_req),
    .arb_adv_o    (arb_adv),
    .ram_ren_o    (acc_ren),
    .ram_raddr_o  (acc_raddr),
    .ram_rdata_i  (ram_rdata),
    .ram_wen_o    (ram_wen),
    .ram_waddr_o  (ram_waddr),
    .ram_wdata_o  (ram_wdata),
    .accum_done_o (accum_done)
  );

  psum_ctrl #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .accum_done_i (accum_done),
    .pool_req_i   (pool_req_i),
    .pool_addr_i  (pool_addr_i),
    .pool_fnh_i   (pool_fnh_i),
    .pool_data_o  (pool_data_o),
    .pool_val_o   (pool_val_o),
    .ram_ren_o    (ctrl_ren),
    .ram_raddr_o  (ctrl_raddr),
    .ram_rdata_i  (ram_rdata),
    .state_o      (state),
    .cfg_o        (pass_cfg),
    .idle_o       (idle_o)
  );

  // Read port belongs to the pool side only in POOL
  assign ram_ren   = (state == POOL) ? ctrl_ren   : acc_ren;
  assign ram_raddr = (state == POOL) ? ctrl_raddr : acc_raddr;

  psum_ram #(
    .DEPTH  (DEPTH),
    .NUM_CH (NUM_CH)
  ) u_ram (
    .clk     (clk),
    .ren_i   (ram_ren),
    .raddr_i (ram_raddr),
    .rdata_o (ram_rdata),
    .wen_i   (ram_wen),
    .waddr_i (ram_waddr),
    .wdata_i (ram_wdata)
  );

endmodule

/* sim/psum_checker.sv */
// Partial-sum bank checker with a model bank, write-port protocol checks and pool data compare
`timescale 1ns/1ps

module psum_checker #(
  parameter int NUM_CH = 3,
  parameter int DEPTH  = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  psum_pkg::pass_cfg_t  cfg_i,
  input  logic                 idle_i,
  input  logic [NUM_CH-1:0]    wr_valid_i,
  input  logic [NUM_CH-1:0]    wr_ready_i,
  input  psum_pkg::psum_word_t wr_data_i [NUM_CH],
  input  logic                 pool_req_i,
  input  psum_pkg::pool_addr_t pool_addr_i,
  input  logic                 pool_val_i,
  input  psum_pkg::psum_t      pool_data_i,
  output int                   err_cnt_o
);
  import psum_pkg::*;

  // Cycles from the last beat to the first POOL cycle
  localparam int POOL_GAP = 4;

  psum_word_t model [NUM_CH][DEPTH];
  int         beats [NUM_CH];
  int         waits [NUM_CH];
  pass_cfg_t  pass_cfg;
  int         since_beat;
  logic       exp_val;
  pool_addr_t exp_addr;
  logic       prev_idle;
  logic       rst_seen;

  initial err_cnt_o = 0;

  // Lane-wise signed sum with wrap that ignores the old word on a first pass
  function automatic psum_word_t accumulate_word(input psum_word_t old_w,
                                                 input psum_word_t new_w,
                                                 input logic first_pass);
    psum_word_t sum_w;
    psum_t      base_l;
    psum_t      add_l;
    for (int l = 0; l < LANES; l++) begin
      base_l = first_pass ? psum_t'(0) : psum_t'(old_w[l*PSUM_W +: PSUM_W]);
      add_l  = psum_t'(new_w[l*PSUM_W +: PSUM_W]);
      sum_w[l*PSUM_W +: PSUM_W] = base_l + add_l;
    end
    return sum_w;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    err_cnt_o++;
  endtask

  task automatic protocol_error(input string text);
    $display("At %0t ns: %s", $time, text);
    err_cnt_o++;
  endtask

  always @(posedge clk or negedge rst_n) begin : watch
    int         n_xfer;
    logic       all_full;
    psum_word_t exp_word;
    if (!rst_n) begin
      exp_val    = 1'b0;
      since_beat = 0;
      prev_idle  = 1'b1;
      rst_seen   = 1'b0;
      pass_cfg   = '0;
      for (int c = 0; c < NUM_CH; c++) begin
        beats[c] = 0;
        waits[c] = 0;
      end
    end else begin
      if (!rst_seen && !idle_i) begin
        value_error("idle_o", idle_i, 1);
      end
      rst_seen = 1'b1;

      // ==================================================
      // Pool answer to the request of the previous cycle
      // ==================================================
      if (pool_val_i !== exp_val) begin
        value_error("pool_val_o", pool_val_i, exp_val);
      end else if (exp_val) begin
        exp_word = model[exp_addr.ch][exp_addr.word];
        if (pool_data_i !== psum_t'(exp_word[exp_addr.lane*PSUM_W +: PSUM_W])) begin
          value_error("pool_data_o", pool_data_i, exp_word[exp_addr.lane*PSUM_W +: PSUM_W]);
        end
      end

      // ==================================================
      // Write port
      // ==================================================
      if (idle_i && wr_ready_i != '0) begin
        value_error("wr_ready_o", wr_ready_i, 0);
      end
      n_xfer = 0;
      for (int c = 0; c < NUM_CH; c++) begin
        if (wr_ready_i[c] && !wr_valid_i[c]) begin
          protocol_error($sformatf("channel %0d got ready without valid", c));
        end
        n_xfer += int'(wr_ready_i[c]);
      end
      if (n_xfer > 1) begin
        protocol_error($sformatf("ready was high on %0d channels at once", n_xfer));
      end
      // A waiting requester loses at most NUM_CH-1 transfers
      for (int c = 0; c < NUM_CH; c++) begin
        if (wr_ready_i[c] || !wr_valid_i[c] || idle_i || beats[c] >= DEPTH) begin
          waits[c] = 0;
        end else begin
          waits[c] += n_xfer;
          if (waits[c] > NUM_CH - 1) begin
            protocol_error($sformatf("channel %0d waited through %0d other transfers",
                                     c, waits[c]));
            waits[c] = 0;
          end
        end
      end
      for (int c = 0; c < NUM_CH; c++) begin
        if (wr_valid_i[c] && wr_ready_i[c]) begin
          if (beats[c] >= DEPTH) begin
            protocol_error($sformatf("channel %0d saw ready after its %0d beats", c, DEPTH));
          end else begin
            model[c][beats[c]] = accumulate_word(model[c][beats[c]], wr_data_i[c],
                                                 pass_cfg.first_pass);
            beats[c]++;
          end
        end
      end

      // Pass progress and pool window
      if (n_xfer > 0) begin
        since_beat = 0;
      end else if (since_beat < POOL_GAP) begin
        since_beat++;
      end
      all_full = 1'b1;
      for (int c = 0; c < NUM_CH; c++) begin
        if (beats[c] != DEPTH) begin
          all_full = 1'b0;
        end
      end
      exp_val  = pool_req_i && !idle_i && pass_cfg.last_pass && all_full &&
                 (since_beat == POOL_GAP);
      exp_addr = pool_addr_i;

      if (idle_i && !prev_idle) begin
        for (int c = 0; c < NUM_CH; c++) begin
          if (beats[c] != DEPTH) begin
            protocol_error($sformatf("channel %0d moved %0d beats in the pass, expected %0d",
                                     c, beats[c], DEPTH));
          end
        end
      end
      if (idle_i) begin
        for (int c = 0; c < NUM_CH; c++) begin
          beats[c] = 0;
          waits[c] = 0;
        end
        if (start_i) begin
          pass_cfg = cfg_i;
        end
      end
      prev_idle = idle_i;
    end
  end

endmodule

/* sim/tb_psum_bank.sv */
// Partial-sum bank testbench with reset, random accumulation passes, pool reads and timeout
`timescale 1ns/1ps

module tb_psum_bank;
  import psum_pkg::*;

  localparam int NUM_CH     = 3;
  localparam int DEPTH      = 16;
  localparam int RST_CYCLES = 16;
  // Four passes of 48 beats with gaps up to four cycles, two pool sweeps and margin
  localparam int TIMEOUT    = 6000;
  // Stage, accum_done and FLUSH cycles before POOL
  localparam int POOL_WAIT  = 3;

  logic              clk;
  logic              rst_n;
  logic              start;
  pass_cfg_t         cfg;
  logic              idle;
  logic [NUM_CH-1:0] wr_valid;
  logic [NUM_CH-1:0] wr_ready;
  psum_word_t        wr_data [NUM_CH];
  logic              pool_req;
  pool_addr_t        pool_addr;
  logic              pool_fnh;
  psum_t             pool_data;
  logic              pool_val;

  int                err_cnt;
  int                err_base;
  int                tests_run;
  int                tests_failed;
  int                cycles = 0;
  logic [31:0]       rng;

  psum_bank_top #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .cfg_i       (cfg),
    .idle_o      (idle),
    .wr_valid_i  (wr_valid),
    .wr_data_i   (wr_data),
    .wr_ready_o  (wr_ready),
    .pool_req_i  (pool_req),
    .pool_addr_i (pool_addr),
    .pool_fnh_i  (pool_fnh),
    .pool_data_o (pool_data),
    .pool_val_o  (pool_val)
  );

  psum_checker #(
    .NUM_CH (NUM_CH),
    .DEPTH  (DEPTH)
  ) u_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .cfg_i       (cfg),
    .idle_i      (idle),
    .wr_valid_i  (wr_valid),
    .wr_ready_i  (wr_ready),
    .wr_data_i   (wr_data),
    .pool_req_i  (pool_req),
    .pool_addr_i (pool_addr),
    .pool_val_i  (pool_val),
    .pool_data_i (pool_data),
    .err_cnt_o   (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin : watchdog
    wait (cycles >= TIMEOUT);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display("Test FAILED");
    $finish;
  end

  // xorshift32 generator
  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function psum_word_t rand_word();
    psum_word_t w;
    for (int l = 0; l < LANES; l++) begin
      w[l*PSUM_W +: PSUM_W] = next_rand();
    end
    return w;
  endfunction

  // ==================================================
  // Sequence tasks
  // ==================================================
  task automatic send_pass(input logic first, input logic last, input int max_gap,
                           input logic hold);
    int   sent [NUM_CH];
    int   gap [NUM_CH];
    logic xfer [NUM_CH];
    logic busy;
    @(posedge clk);
    start          <= 1'b1;
    cfg.first_pass <= first;
    cfg.last_pass  <= last;
    @(posedge clk);
    start <= 1'b0;
    for (int c = 0; c < NUM_CH; c++) begin
      sent[c] = 0;
      gap[c]  = 0;
      xfer[c] = 1'b0;
    end
    busy = 1'b1;
    while (busy) begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (sent[c] >= DEPTH) begin
          // Full channel may keep valid up
          wr_valid[c] <= hold;
        end else if (!wr_valid[c] || xfer[c]) begin
          if (gap[c] > 0) begin
            wr_valid[c] <= 1'b0;
            gap[c]--;
          end else begin
            wr_valid[c] <= 1'b1;
            wr_data[c]  <= rand_word();
            gap[c]      = int'(next_rand() % (max_gap + 1));
          end
        end
      end
      @(posedge clk);
      busy = 1'b0;
      for (int c = 0; c < NUM_CH; c++) begin
        xfer[c] = wr_valid[c] && wr_ready[c];
        if (xfer[c]) begin
          sent[c]++;
        end
        if (sent[c] < DEPTH) begin
          busy = 1'b1;
        end
      end
    end
    if (!hold) begin
      wr_valid <= '0;
    end
  endtask

  task automatic wait_idle();
    while (!idle) begin
      @(posedge clk);
    end
  endtask

  // One request per cycle over every channel, word and lane
  task automatic read_pool();
    for (int c = 0; c < NUM_CH; c++) begin
      for (int w = 0; w < DEPTH; w++) begin
        for (int l = 0; l < LANES; l++) begin
          @(posedge clk);
          pool_req       <= 1'b1;
          pool_addr.ch   <= ch_idx_t'(c);
          pool_addr.word <= word_idx_t'(w);
          pool_addr.lane <= lane_idx_t'(l);
        end
      end
    end
    @(posedge clk);
    pool_req <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic finish_pool();
    @(posedge clk);
    pool_fnh <= 1'b1;
    @(posedge clk);
    pool_fnh <= 1'b0;
    wait_idle();
  endtask

  task automatic report_test(input int num, input string name);
    int errs;
    @(negedge clk);
    errs      = err_cnt - err_base;
    err_base  = err_cnt;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("[%0d] %s: %s, %0d errors", num, name, (errs == 0) ? "pass" : "fail", errs);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin : main
    rng          = 32'hca4e;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    wr_valid     = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      wr_data[c] = '0;
    end
    pool_req  = 1'b0;
    pool_addr = '0;
    pool_fnh  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Pool requests in IDLE go unanswered
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      pool_req       <= 1'b1;
      pool_addr.word <= word_idx_t'(i);
    end
    @(posedge clk);
    pool_req <= 1'b0;
    repeat (2) @(posedge clk);
    report_test(1, "reset state and idle pool requests");

    send_pass(1'b1, 1'b0, 4, 1'b1);
    wait_idle();
    wr_valid <= '0;
    report_test(2, "first pass with valid gaps");

    send_pass(1'b0, 1'b0, 0, 1'b0);
    wait_idle();
    report_test(3, "round-robin under full load");

    send_pass(1'b0, 1'b1, 4, 1'b0);
    repeat (POOL_WAIT) @(posedge clk);
    read_pool();
    report_test(4, "last pass and pool reads");

    finish_pool();
    send_pass(1'b1, 1'b1, 2, 1'b0);
    repeat (POOL_WAIT) @(posedge clk);
    read_pool();
    finish_pool();
    report_test(5, "zero base on a new first pass");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
source/psum_pkg.sv
source/psum_rr_arb.sv
source/psum_ram.sv
source/psum_accum.sv
source/psum_ctrl.sv
source/psum_bank_top.sv
sim/psum_checker.sv
sim/tb_psum_bank.sv
